/* rtl/proj_pkg.sv */
`default_nettype none

package proj_pkg;

  // world space, P and C share one format
  typedef logic signed [15:0] coord_t;

  // camera basis components, Q2.14
  typedef logic signed [15:0] basis_t;
  localparam int BASIS_FRAC = 14;  // fraction bits of basis_t

  // camera relative point, one guard bit over coord_t
  typedef logic signed [$bits(coord_t):0] rel_t;

  // one rel * basis product and the sum of three of them
  typedef logic signed [$bits(rel_t)+$bits(basis_t)-1:0] prod_t;
  typedef logic signed [$bits(prod_t)+1:0] dot_t;  // +2 bits for the 3-term add

  // camera space coordinate, dot product with the Q2.14 fraction dropped
  typedef logic signed [$bits(dot_t)-BASIS_FRAC-1:0] cam_t;

  // quotient bits, one divider stage per bit
  localparam int QUOT_WIDTH = 12;

  // projected coordinate around the viewport centre
  typedef logic signed [QUOT_WIDTH-1:0] screen_t;

  typedef logic [9:0] pixel_t;   // unsigned pixel coordinate
  typedef logic [15:0] depth_t;  // low bits of camera z

endpackage

`default_nettype wire

/* rtl/camera_transform.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_transform (
  input  wire logic            clk_in,
  input  wire logic            rst_in,
  input  wire logic            valid_in,
  input  proj_pkg::coord_t     px,
  input  proj_pkg::coord_t     py,
  input  proj_pkg::coord_t     pz,
  input  proj_pkg::coord_t     cx,
  input  proj_pkg::coord_t     cy,
  input  proj_pkg::coord_t     cz,
  input  proj_pkg::basis_t     ux,
  input  proj_pkg::basis_t     uy,
  input  proj_pkg::basis_t     uz,
  input  proj_pkg::basis_t     vx,
  input  proj_pkg::basis_t     vy,
  input  proj_pkg::basis_t     vz,
  input  proj_pkg::basis_t     nx,
  input  proj_pkg::basis_t     ny,
  input  proj_pkg::basis_t     nz,
  output logic                 valid_out,
  output proj_pkg::cam_t       cam_x,
  output proj_pkg::cam_t       cam_y,
  output proj_pkg::cam_t       cam_z
);

  localparam int FRAC = proj_pkg::BASIS_FRAC;

  proj_pkg::rel_t  rel_x, rel_y, rel_z;     // P - C, sign extended by one bit
  proj_pkg::prod_t prod_u [3];              // terms of P.u
  proj_pkg::prod_t prod_v [3];              // terms of P.v
  proj_pkg::prod_t prod_n [3];              // terms of P.n
  proj_pkg::dot_t  dot_u, dot_v, dot_n;
  logic            valid_s1;

  assign rel_x = px - cx;  // both signed, extended to rel_t width
  assign rel_y = py - cy;
  assign rel_z = pz - cz;

  // valid follows the two data stages
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_s1  <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_s1  <= valid_in;
      valid_out <= valid_s1;
    end
  end

  // stage 1: nine signed multiplies
  always_ff @(posedge clk_in) begin
    prod_u[0] <= rel_x * ux;
    prod_u[1] <= rel_y * uy;
    prod_u[2] <= rel_z * uz;
    prod_v[0] <= rel_x * vx;
    prod_v[1] <= rel_y * vy;
    prod_v[2] <= rel_z * vz;
    prod_n[0] <= rel_x * nx;
    prod_n[1] <= rel_y * ny;
    prod_n[2] <= rel_z * nz;
  end

  assign dot_u = prod_u[0] + prod_u[1] + prod_u[2];
  assign dot_v = prod_v[0] + prod_v[1] + prod_v[2];
  assign dot_n = prod_n[0] + prod_n[1] + prod_n[2];

  // stage 2: drop the basis fraction, arithmetic shift keeps the sign
  always_ff @(posedge clk_in) begin
    cam_x <= proj_pkg::cam_t'(dot_u >>> FRAC);  // camera right
    cam_y <= proj_pkg::cam_t'(dot_v >>> FRAC);  // camera up
    cam_z <= proj_pkg::cam_t'(dot_n >>> FRAC);  // depth along view axis
  end

endmodule

`default_nettype wire

/* rtl/perspective_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module perspective_divider #(
  parameter int FOCAL_SHIFT = 8,
  parameter int NEAR_Z      = 16
) (
  input  wire logic           clk_in,
  input  wire logic           rst_in,
  input  wire logic           valid_in,
  input  proj_pkg::cam_t      cam_x,
  input  proj_pkg::cam_t      cam_y,
  input  proj_pkg::cam_t      cam_z,
  output logic                valid_out,
  output proj_pkg::screen_t   scr_x,
  output proj_pkg::screen_t   scr_y,
  output proj_pkg::depth_t    depth,
  output logic                near_cull
);

  localparam int CAM_W  = $bits(proj_pkg::cam_t);
  localparam int Q_W    = proj_pkg::QUOT_WIDTH;
  localparam int NUM_W  = CAM_W + FOCAL_SHIFT;  // |x| << focal shift
  localparam int WIDE_W = (NUM_W > CAM_W + Q_W) ? NUM_W : CAM_W + Q_W;
  localparam logic [Q_W-1:0] MAX_MAG = {1'b0, {(Q_W-1){1'b1}}};

  function automatic logic [CAM_W-1:0] mag(input proj_pkg::cam_t v);
    return v[CAM_W-1] ? CAM_W'(-v) : CAM_W'(v);  // -min still fits unsigned
  endfunction

  // one restoring step, quotient bit on top of the new remainder
  function automatic logic [WIDE_W:0] div_step(input logic [WIDE_W-1:0] rem,
                                               input logic [WIDE_W-1:0] trial);
    return (rem >= trial) ? {1'b1, rem - trial} : {1'b0, rem};
  endfunction

  // saturate and put the sign back
  function automatic proj_pkg::screen_t finish(input logic [Q_W-1:0] q,
                                               input logic ovf, input logic neg);
    logic [Q_W-1:0] m;
    m = (ovf || q[Q_W-1]) ? MAX_MAG : q;
    return neg ? proj_pkg::screen_t'(-m) : proj_pkg::screen_t'(m);
  endfunction

  logic              near;
  logic [CAM_W-1:0]  div_s;
  logic [WIDE_W-1:0] num_x, num_y;

  // index 0 is the setup stage, 1..Q_W the iteration stages
  logic                v_q    [Q_W+1];
  logic [WIDE_W-1:0]   rx_q   [Q_W+1], ry_q [Q_W+1];   // partial remainders
  logic [Q_W-1:0]      qx_q   [Q_W+1], qy_q [Q_W+1];   // quotient shifted in lsb first
  logic [CAM_W-1:0]    dv_q   [Q_W+1];                 // divisor rides along
  proj_pkg::depth_t    dp_q   [Q_W+1];
  logic                nx_q   [Q_W+1], ny_q [Q_W+1];   // signs of x and y
  logic                ox_q   [Q_W+1], oy_q [Q_W+1];   // quotient too wide
  logic                cull_q [Q_W+1];
  logic [WIDE_W:0]     step_x [1:Q_W], step_y [1:Q_W];

  assign near  = cam_z < NEAR_Z;  // signed compare, behind camera also culls
  assign div_s = near ? CAM_W'(1) : mag(cam_z);  // divide by one when culled
  assign num_x = WIDE_W'(mag(cam_x)) << FOCAL_SHIFT;
  assign num_y = WIDE_W'(mag(cam_y)) << FOCAL_SHIFT;

  always_comb begin
    for (int i = 1; i <= Q_W; i++) begin
      step_x[i] = div_step(rx_q[i-1], WIDE_W'(dv_q[i-1]) << (Q_W - i));
      step_y[i] = div_step(ry_q[i-1], WIDE_W'(dv_q[i-1]) << (Q_W - i));
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i <= Q_W; i++) v_q[i] <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      v_q[0] <= valid_in;
      for (int i = 1; i <= Q_W; i++) v_q[i] <= v_q[i-1];
      valid_out <= v_q[Q_W];
    end
  end

  always_ff @(posedge clk_in) begin
    rx_q[0]   <= num_x;
    ry_q[0]   <= num_y;
    qx_q[0]   <= '0;
    qy_q[0]   <= '0;
    dv_q[0]   <= div_s;
    dp_q[0]   <= proj_pkg::depth_t'(cam_z);
    nx_q[0]   <= cam_x[CAM_W-1];
    ny_q[0]   <= cam_y[CAM_W-1];
    ox_q[0]   <= num_x >= (WIDE_W'(div_s) << Q_W);  // result needs more than Q_W bits
    oy_q[0]   <= num_y >= (WIDE_W'(div_s) << Q_W);
    cull_q[0] <= near;
    for (int i = 1; i <= Q_W; i++) begin
      rx_q[i]   <= step_x[i][WIDE_W-1:0];
      ry_q[i]   <= step_y[i][WIDE_W-1:0];
      qx_q[i]   <= {qx_q[i-1][Q_W-2:0], step_x[i][WIDE_W]};
      qy_q[i]   <= {qy_q[i-1][Q_W-2:0], step_y[i][WIDE_W]};
      dv_q[i]   <= dv_q[i-1];
      dp_q[i]   <= dp_q[i-1];
      nx_q[i]   <= nx_q[i-1];
      ny_q[i]   <= ny_q[i-1];
      ox_q[i]   <= ox_q[i-1];
      oy_q[i]   <= oy_q[i-1];
      cull_q[i] <= cull_q[i-1];
    end
    scr_x     <= finish(qx_q[Q_W], ox_q[Q_W], nx_q[Q_W]);  // sign restore stage
    scr_y     <= finish(qy_q[Q_W], oy_q[Q_W], ny_q[Q_W]);
    depth     <= dp_q[Q_W];
    near_cull <= cull_q[Q_W];
  end

endmodule

`default_nettype wire

/* rtl/viewport_clipper.sv */
`timescale 1ns/1ps
`default_nettype none

module viewport_clipper #(
  parameter int HALF_W = 320,
  parameter int HALF_H = 240
) (
  input  wire logic           clk_in,
  input  wire logic           rst_in,
  input  wire logic           valid_in,
  input  proj_pkg::screen_t   scr_x,
  input  proj_pkg::screen_t   scr_y,
  input  proj_pkg::depth_t    depth,
  input  wire logic           near_cull,
  output logic                valid_out,
  output proj_pkg::pixel_t    pix_x,
  output proj_pkg::pixel_t    pix_y,
  output proj_pkg::depth_t    depth_out,
  output logic                culled
);

  logic off_x, off_y, cull;

  // open interval on both axes, the edge itself is outside
  assign off_x = !((scr_x > -HALF_W) && (scr_x < HALF_W));
  assign off_y = !((scr_y > -HALF_H) && (scr_y < HALF_H));
  assign cull  = near_cull || off_x || off_y;

  always_ff @(posedge clk_in) begin
    if (rst_in) valid_out <= 1'b0;
    else        valid_out <= valid_in;
  end

  always_ff @(posedge clk_in) begin
    culled <= cull;
    if (cull) begin
      pix_x     <= '0;  // culled results carry no position
      pix_y     <= '0;
      depth_out <= '0;
    end else begin
      pix_x     <= proj_pkg::pixel_t'(HALF_W + scr_x);
      pix_y     <= proj_pkg::pixel_t'(HALF_H - scr_y);  // screen y grows downward
      depth_out <= depth;
    end
  end

endmodule

`default_nettype wire

/* rtl/credit_result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_result_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire logic           clk_in,
  input  wire logic           rst_in,
  input  wire logic           valid_in,
  input  proj_pkg::pixel_t    pix_x,
  input  proj_pkg::pixel_t    pix_y,
  input  proj_pkg::depth_t    depth,
  input  wire logic           culled,
  input  wire logic           out_credit,
  output logic                in_credit,
  output logic                out_valid,
  output proj_pkg::pixel_t    out_x,
  output proj_pkg::pixel_t    out_y,
  output proj_pkg::depth_t    out_depth,
  output logic                out_culled
);

  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W = 16;  // sink may run ahead of the queue

  typedef enum logic {GRANT, RUN} state_t;

  state_t            state;
  logic [PTR_W-1:0]  wr_ptr, rd_ptr;
  logic [CNT_W-1:0]  count;       // entries held
  logic [CNT_W-1:0]  grant_left;  // initial credits not yet pulsed
  logic [CRED_W-1:0] credits;     // output credits held
  logic              send;

  proj_pkg::pixel_t  mem_x      [QUEUE_DEPTH];
  proj_pkg::pixel_t  mem_y      [QUEUE_DEPTH];
  proj_pkg::depth_t  mem_depth  [QUEUE_DEPTH];
  logic              mem_culled [QUEUE_DEPTH];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;  // wraps for any depth
  endfunction

  assign send = (count != '0) && (credits != '0);

  // no full check, every entry in flight holds an input credit
  always_ff @(posedge clk_in) begin
    if (valid_in) begin
      mem_x[wr_ptr]      <= pix_x;
      mem_y[wr_ptr]      <= pix_y;
      mem_depth[wr_ptr]  <= depth;
      mem_culled[wr_ptr] <= culled;
    end
  end

  always_ff @(posedge clk_in) begin
    if (send) begin
      out_x      <= mem_x[rd_ptr];
      out_y      <= mem_y[rd_ptr];
      out_depth  <= mem_depth[rd_ptr];
      out_culled <= mem_culled[rd_ptr];
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= GRANT;
      grant_left <= CNT_W'(QUEUE_DEPTH);
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= '0;
      out_valid  <= 1'b0;
      in_credit  <= 1'b0;
    end else begin
      if (valid_in) wr_ptr <= next_ptr(wr_ptr);
      if (send)     rd_ptr <= next_ptr(rd_ptr);
      count     <= count + CNT_W'(valid_in) - CNT_W'(send);
      credits   <= credits + CRED_W'(out_credit) - CRED_W'(send);
      out_valid <= send;  // one pulse per entry, one credit each
      case (state)
        GRANT: begin
          in_credit <= 1'b1;  // back to back after reset
          if (!send) begin  // a send here owes one more pulse, so the count holds
            grant_left <= grant_left - 1'b1;
            if (grant_left == CNT_W'(1)) state <= RUN;
          end
        end
        RUN: in_credit <= send;  // slot freed, hand it back to the source
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/vertex_projector_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vertex_projector_top #(
  parameter int FOCAL_SHIFT = 8,
  parameter int NEAR_Z      = 16,
  parameter int HALF_W      = 320,
  parameter int HALF_H      = 240,
  parameter int QUEUE_DEPTH = 8
) (
  input  wire logic          clk_in,
  input  wire logic          rst_in,
  input  wire logic          in_valid,
  input  proj_pkg::coord_t   in_px,
  input  proj_pkg::coord_t   in_py,
  input  proj_pkg::coord_t   in_pz,
  output logic               in_credit,
  input  proj_pkg::coord_t   cam_cx,
  input  proj_pkg::coord_t   cam_cy,
  input  proj_pkg::coord_t   cam_cz,
  input  proj_pkg::basis_t   cam_ux,
  input  proj_pkg::basis_t   cam_uy,
  input  proj_pkg::basis_t   cam_uz,
  input  proj_pkg::basis_t   cam_vx,
  input  proj_pkg::basis_t   cam_vy,
  input  proj_pkg::basis_t   cam_vz,
  input  proj_pkg::basis_t   cam_nx,
  input  proj_pkg::basis_t   cam_ny,
  input  proj_pkg::basis_t   cam_nz,
  output logic               out_valid,
  output proj_pkg::pixel_t   out_x,
  output proj_pkg::pixel_t   out_y,
  output proj_pkg::depth_t   out_depth,
  output logic               out_culled,
  input  wire logic          out_credit
);

  logic              ct_valid;  // camera space
  proj_pkg::cam_t    ct_x, ct_y, ct_z;
  logic              pd_valid;  // after the divide
  proj_pkg::screen_t pd_x, pd_y;
  proj_pkg::depth_t  pd_depth;
  logic              pd_near;
  logic              vc_valid;  // pixel space
  proj_pkg::pixel_t  vc_x, vc_y;
  proj_pkg::depth_t  vc_depth;
  logic              vc_culled;

  camera_transform u_xform (
    .clk_in(clk_in), .rst_in(rst_in), .valid_in(in_valid),
    .px(in_px), .py(in_py), .pz(in_pz),
    .cx(cam_cx), .cy(cam_cy), .cz(cam_cz),
    .ux(cam_ux), .uy(cam_uy), .uz(cam_uz),
    .vx(cam_vx), .vy(cam_vy), .vz(cam_vz),
    .nx(cam_nx), .ny(cam_ny), .nz(cam_nz),
    .valid_out(ct_valid), .cam_x(ct_x), .cam_y(ct_y), .cam_z(ct_z)
  );

  perspective_divider #(.FOCAL_SHIFT(FOCAL_SHIFT), .NEAR_Z(NEAR_Z)) u_div (
    .clk_in(clk_in), .rst_in(rst_in), .valid_in(ct_valid),
    .cam_x(ct_x), .cam_y(ct_y), .cam_z(ct_z),
    .valid_out(pd_valid), .scr_x(pd_x), .scr_y(pd_y),
    .depth(pd_depth), .near_cull(pd_near)
  );

  viewport_clipper #(.HALF_W(HALF_W), .HALF_H(HALF_H)) u_clip (
    .clk_in(clk_in), .rst_in(rst_in), .valid_in(pd_valid),
    .scr_x(pd_x), .scr_y(pd_y), .depth(pd_depth), .near_cull(pd_near),
    .valid_out(vc_valid), .pix_x(vc_x), .pix_y(vc_y),
    .depth_out(vc_depth), .culled(vc_culled)
  );

  credit_result_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk_in(clk_in), .rst_in(rst_in), .valid_in(vc_valid),
    .pix_x(vc_x), .pix_y(vc_y), .depth(vc_depth), .culled(vc_culled),
    .out_credit(out_credit), .in_credit(in_credit),
    .out_valid(out_valid), .out_x(out_x), .out_y(out_y),
    .out_depth(out_depth), .out_culled(out_culled)
  );

endmodule

`default_nettype wire

/* tb/vertex_projector_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module vertex_projector_assertions (
  input wire logic clk_in,
  input wire logic rst_in,
  input wire logic in_valid,
  input wire logic in_credit,
  input wire logic out_valid,
  input wire logic out_credit
);

  int   in_avail;          // input credits the source holds
  int   out_avail;         // output credits the pipeline holds
  logic seen_rst = 1'b0;   // outputs settle after the first reset edge

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      in_avail  <= 0;
      out_avail <= 0;
      seen_rst  <= 1'b1;
    end else begin
      in_avail  <= in_avail + int'(in_credit) - int'(in_valid);
      out_avail <= out_avail + int'(out_credit) - int'(out_valid);
    end
  end

  a_in_credit: assert property (@(posedge clk_in) disable iff (rst_in)
    in_valid |-> in_avail > 0) else $error("in_valid without an input credit");

  a_out_credit: assert property (@(posedge clk_in) disable iff (rst_in)
    out_valid |-> out_avail > 0) else $error("out_valid without an output credit");

  a_reset_quiet: assert property (@(posedge clk_in)
    rst_in && seen_rst |-> !in_credit && !out_valid) else $error("activity in reset");

endmodule

bind vertex_projector_top vertex_projector_assertions u_assert (
  .clk_in(clk_in), .rst_in(rst_in), .in_valid(in_valid), .in_credit(in_credit),
  .out_valid(out_valid), .out_credit(out_credit)
);

`default_nettype wire

/* tb/tb_vertex_projector.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vertex_projector;

  localparam int QUEUE_DEPTH = 8;
  localparam int LATENCY     = proj_pkg::QUOT_WIDTH + 6;  // sample edge to out_valid edge

  logic clk_in = 1'b0;
  logic rst_in = 1'b1;
  logic in_valid = 1'b0;
  logic out_credit = 1'b0;
  proj_pkg::coord_t in_px = '0, in_py = '0, in_pz = '0;
  proj_pkg::coord_t cam_cx = '0, cam_cy = '0, cam_cz = '0;
  proj_pkg::basis_t cam_ux = '0, cam_uy = '0, cam_uz = '0;
  proj_pkg::basis_t cam_vx = '0, cam_vy = '0, cam_vz = '0;
  proj_pkg::basis_t cam_nx = '0, cam_ny = '0, cam_nz = '0;
  logic in_credit, out_valid, out_culled;
  proj_pkg::pixel_t out_x, out_y;
  proj_pkg::depth_t out_depth;

  int cycle = 0;          // edge counter, read as its pre-edge value
  int credit_pulses = 0;  // in_credit pulses seen
  int sent_count = 0;
  int received = 0;
  int sink_grants = 0;
  int sink_mode = 1;      // 0 free, 1 hold, 2 random
  int errors = 0;
  int checks = 0;
  int latency_id = -1;    // vertex whose latency gets checked
  int exp_x[$], exp_y[$], exp_depth[$], exp_culled[$], exp_id[$], exp_cycle[$];

  vertex_projector_top dut0 (.*);

  always #50 clk_in = ~clk_in;

  always @(posedge clk_in) cycle <= cycle + 1;

  always @(posedge clk_in) begin
    if (in_credit === 1'b1) credit_pulses <= credit_pulses + 1;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic compare(input string name, input int got, input int exp, input int id);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h (vertex %0d)", name, got, exp, id);
    end
  endtask

  // sink: checks each result in order and grants credits by mode
  initial begin
    int id;
    int lat;
    forever begin
      @(posedge clk_in);
      if (out_valid === 1'b1) begin
        received++;
        if (exp_x.size() == 0) begin
          errors++;
          $display("out_valid came with no vertex outstanding");
        end else begin
          id = exp_id.pop_front();
          compare("out_x", out_x, exp_x.pop_front(), id);
          compare("out_y", out_y, exp_y.pop_front(), id);
          compare("out_depth", out_depth, exp_depth.pop_front(), id);
          compare("out_culled", out_culled, exp_culled.pop_front(), id);
          lat = cycle - exp_cycle.pop_front() - 2;  // drive edge and sample edge skew
          if (id == latency_id) compare("latency", lat, LATENCY, id);
        end
      end
      if (rst_in || sink_grants - received >= 4) begin
        out_credit <= 1'b0;  // keep a few credits ahead, no more
      end else if (sink_mode == 0 || (sink_mode == 2 && $urandom % 3 == 0)) begin
        out_credit <= 1'b1;
        sink_grants++;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  // queue full and no sink credits, nothing should move
  task automatic check_hold();
    int p0;
    int r0;
    p0 = credit_pulses;
    r0 = received;
    repeat (40) @(posedge clk_in);
    checks++;
    if (credit_pulses != p0 || received != r0) begin
      errors++;
      $display("in_credit or out_valid kept going while the sink held its credits");
    end
    sink_mode = 2;  // now drain with random grants
  endtask

  task automatic send_vertex(input int v[7], input int gap);
    int waited;
    waited = 0;
    repeat (gap) begin
      @(posedge clk_in);
      in_valid <= 1'b0;
    end
    @(posedge clk_in);
    in_valid <= 1'b0;
    while (credit_pulses - sent_count <= 0) begin
      if (sink_mode == 1) check_hold();
      @(posedge clk_in);
      waited++;
      if (waited > 500) abort_run("timeout waiting for an input credit");
    end
    in_valid <= 1'b1;
    in_px    <= proj_pkg::coord_t'(v[0]);
    in_py    <= proj_pkg::coord_t'(v[1]);
    in_pz    <= proj_pkg::coord_t'(v[2]);
    exp_x.push_back(v[3]);
    exp_y.push_back(v[4]);
    exp_depth.push_back(v[5]);
    exp_culled.push_back(v[6]);
    exp_id.push_back(sent_count);
    exp_cycle.push_back(cycle);
    sent_count++;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk_in);
    in_valid <= 1'b0;
    while (exp_x.size() != 0) begin
      @(posedge clk_in);
      waited++;
      if (waited > 3000) abort_run("timeout waiting for results to drain");
    end
  endtask

  // burst needs an empty queue, every input credit back and a sink credit held
  task automatic wait_burst_ready();
    int waited;
    waited = 0;
    while (credit_pulses - sent_count != QUEUE_DEPTH || sink_grants - received < 1) begin
      @(posedge clk_in);
      waited++;
      if (waited > 200) abort_run("timeout waiting for credits before the burst");
    end
  endtask

  task automatic report_test(input int num, input int mode, input int n, input int e0);
    $display("test %0d mode %0d: %0d vertices, %0d errors", num, mode, n, errors - e0);
  endtask

  initial begin
    int fd;
    int c[12];
    int v[7];
    int num, mode, n_vert, e0, first;
    string line;
    void'($urandom(32'h0ff324f9));
    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;

    // test 1: initial input credits
    e0 = errors;
    repeat (40) @(posedge clk_in);
    compare("in_credit pulses", credit_pulses, QUEUE_DEPTH, -1);
    report_test(1, 1, 0, e0);

    fd = $fopen("tb/projection_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open tb/projection_stimulus.txt");
    num = 0;
    mode = 0;
    n_vert = 0;
    first = 0;
    while ($fgets(line, fd)) begin
      if (line.len() == 0) continue;
      case (line.getc(0))
        "T": begin
          void'($sscanf(line, "T %d %d", num, mode));
          e0 = errors;
          n_vert = 0;
          first = 1;
          if (mode == 1 && sink_grants != received) begin
            errors++;
            $display("sink still holds credits at the start of the hold test");
          end
          sink_mode = (mode == 1) ? 1 : 0;
        end
        "C": begin
          if ($sscanf(line, "C %d %d %d %d %d %d %d %d %d %d %d %d", c[0], c[1], c[2],
                      c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10], c[11]) != 12)
            abort_run("bad camera line in stimulus file");
          wait_drain();  // configuration only changes with nothing in flight
          cam_cx <= proj_pkg::coord_t'(c[0]);
          cam_cy <= proj_pkg::coord_t'(c[1]);
          cam_cz <= proj_pkg::coord_t'(c[2]);
          cam_ux <= proj_pkg::basis_t'(c[3]);
          cam_uy <= proj_pkg::basis_t'(c[4]);
          cam_uz <= proj_pkg::basis_t'(c[5]);
          cam_vx <= proj_pkg::basis_t'(c[6]);
          cam_vy <= proj_pkg::basis_t'(c[7]);
          cam_vz <= proj_pkg::basis_t'(c[8]);
          cam_nx <= proj_pkg::basis_t'(c[9]);
          cam_ny <= proj_pkg::basis_t'(c[10]);
          cam_nz <= proj_pkg::basis_t'(c[11]);
        end
        "V": begin
          if ($sscanf(line, "V %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6]) != 7)
            abort_run("bad vertex line in stimulus file");
          if (mode == 2 && first) begin
            wait_burst_ready();
            latency_id = sent_count;
          end
          send_vertex(v, (mode == 2) ? 0 : $urandom % 3);
          first = 0;
          n_vert++;
        end
        "E": begin
          wait_drain();
          report_test(num, mode, n_vert, e0);
        end
        default: ;  // comments and blank lines
      endcase
    end
    $fclose(fd);
    wait_drain();

    $display("checks %0d, errors %0d, vertices %0d", checks, errors, sent_count);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/projection_stimulus.txt */
# T test mode (0 free sink, 1 sink holds then random grants, 2 burst with latency check)
# C cx cy cz ux uy uz vx vy vz nx ny nz ; V px py pz exp_x exp_y exp_depth exp_culled ; E ends test
T 2 1
C 0 0 0 16384 0 0 0 16384 0 0 0 16384
V 0 0 100 320 240 100 0
V 100 50 200 448 176 200 0
V -100 -50 200 192 304 200 0
V 37 -21 300 351 257 300 0
V 250 180 1000 384 194 1000 0
V 10 10 15 0 0 0 1
V 0 0 -50 0 0 0 1
V 0 0 16 320 240 16 0
V 400 0 256 0 0 0 1
V 320 0 256 0 0 0 1
V 319 0 256 639 240 256 0
V 0 240 256 0 0 0 1
V 0 -239 256 320 479 256 0
V -119 93 97 0 0 0 1
V 5000 0 16 0 0 0 1
E
# rotated camera, looking along +x, then 45 degrees about y
T 3 0
C 10 20 30 0 0 -16384 0 16384 0 16384 0 0
V 210 70 -70 448 176 200 0
V 110 20 80 192 240 100 0
V 15 20 30 0 0 0 1
C 0 0 0 11585 0 -11585 0 16384 0 11585 0 11585
V 100 20 300 192 222 282 0
V -50 40 150 0 0 0 1
V 200 -30 200 320 267 282 0
E
# burst over all input credits
T 4 2
C 0 0 0 16384 0 0 0 16384 0 0 0 16384
V 0 0 100 320 240 100 0
V 64 32 128 448 176 128 0
V -64 -32 128 192 304 128 0
V 50 25 400 352 224 400 0
V 1000 0 100 0 0 0 1
V -3 7 64 308 212 64 0
V 0 0 8 0 0 0 1
V 5 -5 1280 321 241 1280 0
E

/* tb.f */
rtl/proj_pkg.sv
rtl/camera_transform.sv
rtl/perspective_divider.sv
rtl/viewport_clipper.sv
rtl/credit_result_queue.sv
rtl/vertex_projector_top.sv
tb/vertex_projector_assertions.sv
tb/tb_vertex_projector.sv

/* Makefile */
TOP = tb_vertex_projector

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
